//--- src/busSizer_defs.svh
`ifndef BUS_SIZER_DEFS_SVH
`define BUS_SIZER_DEFS_SVH

//////////////////////////////
// Bus geometry
//////////////////////////////

// Width of the CPU and Amiga data buses
`define BS_DATA_W 32

// Width of a single byte lane
`define BS_LANE_W 8

// Number of byte lanes on each data bus
`define BS_LANE_CNT 4

// A 68040 line transfer moves four longwords
`define BS_BURST_BEATS 4

`endif

//--- src/busSizerPkg.sv
package busSizerPkg;

`include "busSizer_defs.svh"

    // Beats in one line burst, visible to modules that count them
    localparam int BURST_BEATS = `BS_BURST_BEATS;

    //////////////////////////////
    // Bus vectors
    //////////////////////////////

    // One full data bus word
    typedef logic [`BS_DATA_W-1:0] dataWord_t;

    // Half of the bus, two byte lanes wide
    typedef logic [(`BS_LANE_CNT/2)*`BS_LANE_W-1:0] halfWord_t;

    // A1..A0 of the CPU or Amiga address
    typedef logic [1:0] addrLow_t;

    // SIZ1..SIZ0, equal bits mean longword or line and 2'b11 is a line
    typedef logic [1:0] xferSize_t;

    // Counts the beats of a line burst
    typedef logic [$clog2(BURST_BEATS)-1:0] beatCount_t;

    // Termination pair as {acknowledge, error}, both active low
    typedef enum logic [1:0] {
        RETRY  = 2'b00,
        NORMAL = 2'b01,
        ERROR  = 2'b10,
        WAIT   = 2'b11
    } termCode_t;

    // Transfer and bus-sizing sequencer states
    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        FIRST_WAIT,
        SPLIT_START,
        SPLIT_ADDR,
        SPLIT_WAIT
    } seqState_t;

endpackage

//--- src/laneCtrlIf.sv
`timescale 1ns/1ps
`include "busSizer_defs.svh"

// Lane steering controls from the sequencer to the data lane block
interface laneCtrlIf;

    // Direction of the running CPU cycle, at most one is high
    logic readActive;
    logic writeActive;

    // Swap the upper and lower word lanes
    logic flipWord;

    // Single cycle strobe that captures the Amiga upper word
    logic latchUpper;

    // Present the captured word on the CPU upper lanes
    logic useLatched;

    // The sequencer drives every control
    modport seq (
        output readActive, writeActive, flipWord, latchUpper, useLatched
    );

    // The data lanes only follow the controls
    modport lanes (
        input readActive, writeActive, flipWord, latchUpper, useLatched
    );

endinterface

//--- src/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer
    import busSizerPkg::*;
(
    input  logic      CLK40,
    input  logic      RESETn,
    input  logic      rnw,
    input  logic      portSize,
    input  logic      lbenN,
    input  xferSize_t siz,
    input  addrLow_t  addrCpu,
    input  logic      tsCpuN,
    input  logic      tackN,
    input  logic      teaN,
    input  logic      tbiN,
    output logic      tsStart,
    output logic      taBlock,
    output logic      a2Force,
    laneCtrlIf.seq    lane
);

    seqState_t  state;
    seqState_t  nextState;
    termCode_t  term;
    beatCount_t beatCount;
    logic       tsSeen;
    logic       lwTrans;
    logic       burst;
    logic       portMismatch;
    logic       cycleStart;
    logic       lastBeat;
    logic       toIdle;

    // The target answers with the acknowledge and error pair
    assign term = termCode_t'({tackN, teaN});

    // On-board cycles are left alone, only off-board strobes start a cycle
    assign cycleStart = !tsSeen && lbenN;

    // A beat ends the cycle unless a line burst still has beats to go
    // and the target allows bursting
    assign lastBeat = !burst || !tbiN || (beatCount == beatCount_t'(BURST_BEATS - 1));

    assign toIdle = (state != IDLE) && (nextState == IDLE);

    // The upper word of the first split read is caught as it terminates
    assign lane.latchUpper = (state == FIRST_WAIT) && (term == NORMAL)
                             && portMismatch && lane.readActive;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (cycleStart) begin
                    nextState = SETUP;
                end
            end
            SETUP: begin
                nextState = FIRST_WAIT;
            end
            FIRST_WAIT: begin
                case (term)
                    NORMAL: begin
                        // A mismatched port needs a second local cycle at address 2
                        if (portMismatch) begin
                            nextState = SPLIT_START;
                        end else if (lastBeat) begin
                            nextState = IDLE;
                        end
                    end
                    RETRY, ERROR: nextState = IDLE;
                    default: nextState = state;
                endcase
            end
            SPLIT_START: begin
                nextState = SPLIT_ADDR;
            end
            SPLIT_ADDR: begin
                nextState = SPLIT_WAIT;
            end
            SPLIT_WAIT: begin
                case (term)
                    NORMAL:       nextState = lastBeat ? IDLE : SETUP;
                    RETRY, ERROR: nextState = IDLE;
                    default:      nextState = state;
                endcase
            end
            default: nextState = IDLE;
        endcase
    end

    //////////////////////////////
    // State and control registers
    //////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state            <= IDLE;
            tsSeen           <= 1'b1;
            tsStart          <= 1'b0;
            taBlock          <= 1'b0;
            a2Force          <= 1'b0;
            lwTrans          <= 1'b0;
            burst            <= 1'b0;
            portMismatch     <= 1'b0;
            beatCount        <= '0;
            lane.readActive  <= 1'b0;
            lane.writeActive <= 1'b0;
            lane.flipWord    <= 1'b0;
            lane.useLatched  <= 1'b0;
        end else begin
            tsSeen  <= tsCpuN;
            state   <= nextState;
            tsStart <= 1'b0;

            case (state)
                IDLE: begin
                    if (cycleStart) begin
                        lane.readActive  <= rnw;
                        lane.writeActive <= !rnw;
                        lwTrans          <= (siz[1] == siz[0]);
                        burst            <= (siz == 2'b11);
                        beatCount        <= '0;
                        // Hold back the acknowledge early so that no stray
                        // termination of a split beat reaches the CPU
                        taBlock          <= portSize && (siz[1] == siz[0]);
                    end
                end
                SETUP: begin
                    portMismatch    <= portSize && lwTrans;
                    // A word at address 2 of a word port sits on the upper lanes
                    lane.flipWord   <= portSize && addrCpu[1];
                    lane.useLatched <= 1'b0;
                end
                FIRST_WAIT: begin
                    if (term == NORMAL) begin
                        if (portMismatch) begin
                            tsStart <= 1'b1;
                            a2Force <= 1'b1;
                        end else begin
                            beatCount <= beatCount + 1'b1;
                        end
                    end
                end
                SPLIT_START: begin
                    // The second cycle ends the CPU beat
                    taBlock         <= 1'b0;
                    lane.flipWord   <= 1'b1;
                    lane.useLatched <= lane.readActive;
                end
                SPLIT_WAIT: begin
                    if (term == NORMAL) begin
                        a2Force   <= 1'b0;
                        beatCount <= beatCount + 1'b1;
                        if (!lastBeat) begin
                            // Next burst beat opens with its own Amiga strobe
                            tsStart <= 1'b1;
                            taBlock <= 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase

            // Leaving for IDLE drops every lane and address control
            if (toIdle) begin
                lane.readActive  <= 1'b0;
                lane.writeActive <= 1'b0;
                lane.flipWord    <= 1'b0;
                lane.useLatched  <= 1'b0;
                taBlock          <= 1'b0;
                a2Force          <= 1'b0;
                portMismatch     <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Every split strobe is a single cycle request
    tsStartPulse: assert property (@(posedge CLK40) disable iff (!RESETn)
        tsStart |=> !tsStart);

    // The data buffers never drive in both directions
    oneDirection: assert property (@(posedge CLK40) disable iff (!RESETn)
        !(lane.readActive && lane.writeActive));

    // Address 2 is only forced inside a running cycle
    a2InCycle: assert property (@(posedge CLK40) disable iff (!RESETn)
        a2Force |-> (state != IDLE));

endmodule

//--- src/dataLaneSteer.sv
`timescale 1ns/1ps
`include "busSizer_defs.svh"

module dataLaneSteer
    import busSizerPkg::*;
(
    input  logic       CLK40,
    input  logic       RESETn,
    laneCtrlIf.lanes   lane,
    input  dataWord_t  dataCpuIn,
    input  dataWord_t  dataAmigaIn,
    output dataWord_t  dataCpuOut,
    output dataWord_t  dataAmigaOut,
    output logic       dataCpuOe,
    output logic       dataAmigaOe
);

    // Two byte lanes make one word
    localparam int HALF_W = (`BS_LANE_CNT / 2) * `BS_LANE_W;

    halfWord_t cpuUpper;
    halfWord_t cpuLower;
    halfWord_t amigaUpper;
    halfWord_t amigaLower;
    halfWord_t upperLatch;
    halfWord_t cpuReadUpper;
    halfWord_t cpuReadLower;
    halfWord_t amigaWriteUpper;
    logic      latchValid;

    // Word views of both buses, upper lanes hold the address 0 word
    assign cpuUpper   = dataCpuIn[`BS_DATA_W-1 -: HALF_W];
    assign cpuLower   = dataCpuIn[HALF_W-1:0];
    assign amigaUpper = dataAmigaIn[`BS_DATA_W-1 -: HALF_W];
    assign amigaLower = dataAmigaIn[HALF_W-1:0];

    //////////////////////////////
    // Read path
    //////////////////////////////

    // A word port only drives its upper lanes, so a flipped read moves
    // that word down to where the CPU expects address 2
    assign cpuReadLower = lane.flipWord ? amigaUpper : amigaLower;

    // During the second half of a split read the first word comes from the latch
    assign cpuReadUpper = lane.useLatched ? upperLatch : amigaUpper;

    assign dataCpuOut = {cpuReadUpper, cpuReadLower};

    //////////////////////////////
    // Write path
    //////////////////////////////

    // The word port sees only its upper lanes, a flipped write puts the
    // CPU lower word there
    assign amigaWriteUpper = lane.flipWord ? cpuLower : cpuUpper;

    // Lower lanes carry the CPU lower word for longword ports
    assign dataAmigaOut = {amigaWriteUpper, cpuLower};

    // Buffer direction comes straight from the cycle type
    assign dataCpuOe   = lane.readActive;
    assign dataAmigaOe = lane.writeActive;

    //////////////////////////////
    // Read word latch
    //////////////////////////////

    // Keeps the first word of a split read while the second cycle runs
    always_ff @(posedge CLK40) begin
        if (lane.latchUpper) begin
            upperLatch <= amigaUpper;
        end
    end

    // Tracks whether the latch holds a word of the current read
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            latchValid <= 1'b0;
        end else if (lane.latchUpper) begin
            latchValid <= 1'b1;
        end else if (!lane.readActive) begin
            latchValid <= 1'b0;
        end
    end

    // The latched word is only shown after it was captured in this read
    latchBeforeUse: assert property (@(posedge CLK40) disable iff (!RESETn)
        lane.useLatched |-> latchValid);

endmodule

//--- src/termRouter.sv
`timescale 1ns/1ps

module termRouter
    import busSizerPkg::*;
(
    input  logic CLK40,
    input  logic RESETn,
    input  logic tsCpuN,
    input  logic lbenN,
    input  logic tsStart,
    input  logic taBlock,
    input  logic tackN,
    input  logic teaN,
    input  logic tbiN,
    input  logic tciN,
    output logic tsAmigaN,
    output logic taCpuN,
    output logic teaCpuN,
    output logic tbiCpuN,
    output logic tciCpuN
);

    termCode_t term;
    logic      ackIn;

    //////////////////////////////
    // Transfer start
    //////////////////////////////

    // Off-board CPU strobes are copied one cycle late and split cycles
    // add their own strobe on request of the sequencer
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            tsAmigaN <= 1'b1;
        end else begin
            tsAmigaN <= !((!tsCpuN && lbenN) || tsStart);
        end
    end

    //////////////////////////////
    // Termination
    //////////////////////////////

    assign term = termCode_t'({tackN, teaN});

    // Normal and retry both carry a low acknowledge
    assign ackIn = (term == NORMAL) || (term == RETRY);

    // The first half of a split beat is absorbed here
    assign taCpuN = !(ackIn && !taBlock);

    // Errors always reach the CPU so a failed split cannot hang it
    assign teaCpuN = teaN;

    // On-board memory answers the CPU itself so both inhibits stay high
    assign tbiCpuN = lbenN ? tbiN : 1'b1;
    assign tciCpuN = lbenN ? tciN : 1'b1;

endmodule

//--- src/busSizer.sv
`timescale 1ns/1ps

module busSizer
    import busSizerPkg::*;
(
    input  logic      CLK40,
    input  logic      RESETn,
    input  logic      rnw,
    input  logic      portSize,
    input  logic      lbenN,
    input  xferSize_t siz,
    input  addrLow_t  addrCpu,
    input  logic      tsCpuN,
    input  logic      tackN,
    input  logic      teaN,
    input  logic      tbiN,
    input  logic      tciN,
    input  dataWord_t dataCpuIn,
    input  dataWord_t dataAmigaIn,
    output logic      tsAmigaN,
    output logic      taCpuN,
    output logic      teaCpuN,
    output logic      tbiCpuN,
    output logic      tciCpuN,
    output addrLow_t  addrAmiga,
    output dataWord_t dataCpuOut,
    output logic      dataCpuOe,
    output dataWord_t dataAmigaOut,
    output logic      dataAmigaOe
);

    logic tsStart;
    logic taBlock;
    logic a2Force;

    laneCtrlIf i_laneCtrlIf ();

    // The second cycle of a split runs at address 2, all other cycles
    // use the CPU address as is
    assign addrAmiga = a2Force ? addrLow_t'(2'b10) : addrCpu;

    //////////////////////////////
    // Blocks
    //////////////////////////////

    cycleSequencer i_cycleSequencer (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .rnw      (rnw),
        .portSize (portSize),
        .lbenN    (lbenN),
        .siz      (siz),
        .addrCpu  (addrCpu),
        .tsCpuN   (tsCpuN),
        .tackN    (tackN),
        .teaN     (teaN),
        .tbiN     (tbiN),
        .tsStart  (tsStart),
        .taBlock  (taBlock),
        .a2Force  (a2Force),
        .lane     (i_laneCtrlIf.seq)
    );

    dataLaneSteer i_dataLaneSteer (
        .CLK40        (CLK40),
        .RESETn       (RESETn),
        .lane         (i_laneCtrlIf.lanes),
        .dataCpuIn    (dataCpuIn),
        .dataAmigaIn  (dataAmigaIn),
        .dataCpuOut   (dataCpuOut),
        .dataAmigaOut (dataAmigaOut),
        .dataCpuOe    (dataCpuOe),
        .dataAmigaOe  (dataAmigaOe)
    );

    // Strobe output and termination forwarding toward the CPU
    termRouter i_termRouter (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .tsCpuN   (tsCpuN),
        .lbenN    (lbenN),
        .tsStart  (tsStart),
        .taBlock  (taBlock),
        .tackN    (tackN),
        .teaN     (teaN),
        .tbiN     (tbiN),
        .tciN     (tciN),
        .tsAmigaN (tsAmigaN),
        .taCpuN   (taCpuN),
        .teaCpuN  (teaCpuN),
        .tbiCpuN  (tbiCpuN),
        .tciCpuN  (tciCpuN)
    );

endmodule

//--- tb/busSizerTb.sv
`timescale 1ns/1ps
`include "busSizer_defs.svh"

module busSizerTb
    import busSizerPkg::*;
();

    logic      CLK40;
    logic      RESETn;
    logic      rnw;
    logic      portSize;
    logic      lbenN;
    xferSize_t siz;
    addrLow_t  addrCpu;
    logic      tsCpuN;
    logic      tackN;
    logic      teaN;
    logic      tbiN;
    logic      tciN;
    dataWord_t dataCpuIn;
    dataWord_t dataAmigaIn;
    logic      tsAmigaN;
    logic      taCpuN;
    logic      teaCpuN;
    logic      tbiCpuN;
    logic      tciCpuN;
    addrLow_t  addrAmiga;
    dataWord_t dataCpuOut;
    logic      dataCpuOe;
    dataWord_t dataAmigaOut;
    logic      dataAmigaOe;

    // Stimulus state and result bookkeeping
    logic [31:0] lfsr = 32'hbff8e233;
    string       testName;
    int          errors;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    logic        aborted;
    logic        pick;
    int          i;

    busSizer i_busSizer (
        .CLK40(CLK40), .RESETn(RESETn), .rnw(rnw), .portSize(portSize), .lbenN(lbenN),
        .siz(siz), .addrCpu(addrCpu), .tsCpuN(tsCpuN), .tackN(tackN), .teaN(teaN),
        .tbiN(tbiN), .tciN(tciN), .dataCpuIn(dataCpuIn), .dataAmigaIn(dataAmigaIn),
        .tsAmigaN(tsAmigaN), .taCpuN(taCpuN), .teaCpuN(teaCpuN), .tbiCpuN(tbiCpuN),
        .tciCpuN(tciCpuN), .addrAmiga(addrAmiga), .dataCpuOut(dataCpuOut),
        .dataCpuOe(dataCpuOe), .dataAmigaOut(dataAmigaOut), .dataAmigaOe(dataAmigaOe)
    );

    // 100 ns period
    always #50 CLK40 = ~CLK40;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per returned bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
            errors++;
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end else if (aborted) begin
            $display("test %s skipped", testName);
        end else begin
            $display("test %s ok", testName);
        end
    endtask

    // Polls at every falling edge, the current one included
    task automatic waitStrobe(output logic seen);
        int k;
        seen = 1'b0;
        for (k = 0; k < 50 && !seen; k++) begin
            if (!tsAmigaN) begin
                seen = 1'b1;
            end else begin
                @(negedge CLK40);
            end
        end
        if (!seen) begin
            $display("Timeout in %s: no Amiga transfer start within 50 cycles", testName);
            errors++;
            testErrors++;
            aborted = 1'b1;
        end
    endtask

    // Once a cycle ends no strobe may follow and the buffers are off
    task automatic quietCheck(input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            checkEq("idle strobe", 32'(1'b1), 32'(tsAmigaN));
            checkEq("idle enables", 32'(2'b00), 32'({dataCpuOe, dataAmigaOe}));
            @(negedge CLK40);
        end
    endtask

    //////////////////////////////
    // Target and reference model
    //////////////////////////////

    // Runs one CPU cycle while acting as the Amiga target, errAt picks the
    // termination that answers with ERROR
    task automatic runXfer(input logic read, input logic wordPort, input xferSize_t sz,
                           input addrLow_t addr, input int errAt);
        logic      split;
        logic      isBurst;
        logic      flip;
        logic      lastTerm;
        logic      seen;
        logic      done;
        int        beat;
        int        half;
        int        termIdx;
        termCode_t termSel;
        dataWord_t cpuWord;
        dataWord_t amigaWord;
        halfWord_t firstUpper;
        split      = wordPort && (sz[1] == sz[0]);
        isBurst    = (sz == 2'b11);
        flip       = wordPort && addr[1];
        cpuWord    = randBits(32);
        firstUpper = '0;
        termIdx    = 0;
        done       = 1'b0;
        @(negedge CLK40);
        rnw       = read;
        portSize  = wordPort;
        siz       = sz;
        addrCpu   = addr;
        lbenN     = 1'b1;
        dataCpuIn = cpuWord;
        tsCpuN    = 1'b0;
        @(negedge CLK40);
        tsCpuN = 1'b1;
        for (beat = 0; beat < `BS_BURST_BEATS && !done; beat++) begin
            for (half = 0; half < (split ? 2 : 1) && !done; half++) begin
                lastTerm = !split || (half == 1);
                // A like port takes every burst beat on the first strobe
                if (split || beat == 0) begin
                    waitStrobe(seen);
                    if (!seen) begin
                        return;
                    end
                    checkEq("address", 32'((half == 1) ? 2'd2 : addr), 32'(addrAmiga));
                    // Address decode of the target before its wait states
                    repeat (2) @(negedge CLK40);
                end
                repeat (randBits(2)) @(negedge CLK40);
                amigaWord     = randBits(32);
                termSel       = (termIdx == errAt) ? ERROR : NORMAL;
                dataAmigaIn   = amigaWord;
                tciN          = 1'(randBits(1));
                tbiN          = (isBurst && lastTerm) ? (randBits(2) != 0) : 1'b1;
                {tackN, teaN} = termSel;
                #1;
                // Only the last local cycle of a beat acknowledges the CPU
                checkEq("taCpuN", 32'(!(termSel == NORMAL && lastTerm)), 32'(taCpuN));
                checkEq("teaCpuN", 32'(termSel != ERROR), 32'(teaCpuN));
                checkEq("inhibits", 32'({tbiN, tciN}), 32'({tbiCpuN, tciCpuN}));
                checkEq("enables", 32'({read, !read}), 32'({dataCpuOe, dataAmigaOe}));
                if (read && split && half == 0) begin
                    firstUpper = amigaWord[31:16];
                end
                if (read && lastTerm && termSel == NORMAL) begin
                    if (split) begin
                        checkEq("read data", {firstUpper, amigaWord[31:16]}, dataCpuOut);
                    end else begin
                        checkEq("read data", {amigaWord[31:16],
                                flip ? amigaWord[31:16] : amigaWord[15:0]}, dataCpuOut);
                    end
                end
                // Word port writes land on the upper lanes
                if (!read) begin
                    checkEq("write data", {(flip || half == 1) ? cpuWord[15:0] : cpuWord[31:16],
                            cpuWord[15:0]}, dataAmigaOut);
                end
                done = (termSel == ERROR) || (lastTerm && (!isBurst || !tbiN));
                termIdx++;
                @(negedge CLK40);
                {tackN, teaN} = WAIT;
                tbiN          = 1'b1;
            end
        end
        quietCheck(5);
    endtask

    // CPU strobes for on-board memory must never reach the Amiga side
    task automatic onBoardCheck();
        int k;
        int n;
        for (k = 0; k < 3; k++) begin
            @(negedge CLK40);
            lbenN  = 1'b0;
            rnw    = 1'(randBits(1));
            siz    = 2'(randBits(2));
            tbiN   = 1'(randBits(1));
            tciN   = 1'(randBits(1));
            tsCpuN = 1'b0;
            for (n = 0; n < 5; n++) begin
                @(negedge CLK40);
                tsCpuN = 1'b1;
                checkEq("outputs", 32'(5'h1f), 32'({tsAmigaN, taCpuN, teaCpuN, tbiCpuN, tciCpuN}));
                checkEq("enables", 32'(2'b00), 32'({dataCpuOe, dataAmigaOe}));
            end
        end
        lbenN = 1'b1;
        tbiN  = 1'b1;
        tciN  = 1'b1;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        CLK40       = 1'b0;
        RESETn      = 1'b0;
        rnw         = 1'b1;
        portSize    = 1'b0;
        lbenN       = 1'b1;
        siz         = 2'b00;
        addrCpu     = 2'b01;
        tsCpuN      = 1'b1;
        tackN       = 1'b1;
        teaN        = 1'b1;
        tbiN        = 1'b1;
        tciN        = 1'b1;
        dataCpuIn   = '0;
        dataAmigaIn = '0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        aborted     = 1'b0;
        repeat (8) @(negedge CLK40);
        RESETn = 1'b1;

        startTest("reset");
        @(negedge CLK40);
        checkEq("outputs", 32'(5'h1f), 32'({tsAmigaN, taCpuN, teaCpuN, tbiCpuN, tciCpuN}));
        checkEq("enables", 32'(2'b00), 32'({dataCpuOe, dataAmigaOe}));
        checkEq("address", 32'(addrCpu), 32'(addrAmiga));
        endTest();

        startTest("onBoard");
        onBoardCheck();
        endTest();

        startTest("longPort");
        for (i = 0; i < 6 && !aborted; i++) begin
            runXfer(1'(randBits(1)), 1'b0, 2'b00, 2'(randBits(2)), -1);
        end
        endTest();

        startTest("wordPortWord");
        for (i = 0; i < 6 && !aborted; i++) begin
            runXfer(1'(randBits(1)), 1'b1, 2'b10, {1'(randBits(1)), 1'b0}, -1);
        end
        endTest();

        startTest("splitRead");
        for (i = 0; i < 4 && !aborted; i++) begin
            runXfer(1'b1, 1'b1, 2'b00, 2'b00, -1);
        end
        endTest();

        startTest("splitWrite");
        for (i = 0; i < 4 && !aborted; i++) begin
            runXfer(1'b0, 1'b1, 2'b00, 2'b00, -1);
        end
        endTest();

        startTest("lineLongPort");
        for (i = 0; i < 4 && !aborted; i++) begin
            runXfer(1'(randBits(1)), 1'b0, 2'b11, 2'b00, -1);
        end
        endTest();

        startTest("lineWordPort");
        for (i = 0; i < 4 && !aborted; i++) begin
            runXfer(1'(randBits(1)), 1'b1, 2'b11, 2'b00, -1);
        end
        endTest();

        // Errors hit single, split and burst cycles at a random termination
        startTest("errorTerm");
        for (i = 0; i < 6 && !aborted; i++) begin
            pick = 1'(randBits(1));
            runXfer(1'(randBits(1)), 1'(randBits(1)), {pick, pick}, 2'b00, int'(randBits(2)));
        end
        endTest();

        $display("%0d tests, %0d failed, %0d check errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+src
src/busSizerPkg.sv
src/laneCtrlIf.sv
src/cycleSequencer.sv
src/dataLaneSteer.sv
src/termRouter.sv
src/busSizer.sv
tb/busSizerTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the bus sizer testbench with Verilator and runs it into sim.log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module busSizerTb -o simBusSizer

./obj_dir/simBusSizer | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
